/* logic/exu_alu_pkg.sv */
// exu_alu shared definitions
// instruction views, operation codes and the stream payload structs

package exu_alu_pkg;

    // data width, fixed by the RV32I encoding
    localparam int unsigned xlen = 32;

    // major opcodes accepted by the unit
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;

    // funct7 values, base and alternate (sub, sra, srai)
    localparam logic [6:0] funct7_base = 7'h00;
    localparam logic [6:0] funct7_alt  = 7'h20;

    // funct3 values shared by OP and OP-IMM
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // R-type view, also used for shift immediates
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    // I-type view
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    // one instruction word, two decodings
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } alu_instr_u;

    typedef enum logic [3:0] {
        alu_none = 4'd0,
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    // registered request, 69 bits
    typedef struct packed {
        alu_op_e           op;
        logic [xlen-1:0]   op1;
        logic [xlen-1:0]   op2;
        logic              illegal;
    } alu_req_t;

    // response, 33 bits
    typedef struct packed {
        logic [xlen-1:0]   result;
        logic              illegal;
    } alu_rsp_t;

    // input command, 96 bits
    typedef struct packed {
        alu_instr_u        instr;
        logic [xlen-1:0]   rs1_val;
        logic [xlen-1:0]   rs2_val;
    } alu_cmd_t;

endpackage

/* logic/exu_alu_decoder.sv */
// exu_alu input stage
// decodes OP / OP-IMM words into an operation and operands, then registers the request
`timescale 1ns/1ps

module exu_alu_decoder (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   in_valid_i,
    input  exu_alu_pkg::alu_cmd_t  in_cmd_i,
    input  logic                   stage1_ready_i,
    output logic                   in_ready_o,
    output logic                   req_valid_o,
    output exu_alu_pkg::alu_req_t  req_o
);

    exu_alu_pkg::alu_instr_u instr;
    exu_alu_pkg::alu_req_t   req_d;
    logic                    f7_zero;
    logic                    f7_alt;
    logic                    load;

    assign instr   = in_cmd_i.instr;
    // funct7 read through the r view for both OP and shift immediates
    assign f7_zero = (instr.r.funct7 == exu_alu_pkg::funct7_base);
    assign f7_alt  = (instr.r.funct7 == exu_alu_pkg::funct7_alt);

    always_comb begin
        req_d.op      = exu_alu_pkg::alu_none;
        req_d.op1     = in_cmd_i.rs1_val;
        req_d.op2     = in_cmd_i.rs2_val;
        req_d.illegal = 1'b0;
        if (instr.r.opcode == exu_alu_pkg::opc_op) begin
            // register-register, funct7 must be 0 or 0x20 where allowed
            case (instr.r.funct3)
                exu_alu_pkg::f3_add_sub:
                    req_d.op = f7_zero ? exu_alu_pkg::alu_add :
                               f7_alt  ? exu_alu_pkg::alu_sub : exu_alu_pkg::alu_none;
                exu_alu_pkg::f3_sll:
                    req_d.op = f7_zero ? exu_alu_pkg::alu_sll : exu_alu_pkg::alu_none;
                exu_alu_pkg::f3_slt:
                    req_d.op = f7_zero ? exu_alu_pkg::alu_slt : exu_alu_pkg::alu_none;
                exu_alu_pkg::f3_sltu:
                    req_d.op = f7_zero ? exu_alu_pkg::alu_sltu : exu_alu_pkg::alu_none;
                exu_alu_pkg::f3_xor:
                    req_d.op = f7_zero ? exu_alu_pkg::alu_xor : exu_alu_pkg::alu_none;
                exu_alu_pkg::f3_srl_sra:
                    req_d.op = f7_zero ? exu_alu_pkg::alu_srl :
                               f7_alt  ? exu_alu_pkg::alu_sra : exu_alu_pkg::alu_none;
                exu_alu_pkg::f3_or:
                    req_d.op = f7_zero ? exu_alu_pkg::alu_or : exu_alu_pkg::alu_none;
                default:
                    req_d.op = f7_zero ? exu_alu_pkg::alu_and : exu_alu_pkg::alu_none;
            endcase
        end else if (instr.i.opcode == exu_alu_pkg::opc_op_imm) begin
            // sign-extended immediate replaces rs2
            req_d.op2 = {{(exu_alu_pkg::xlen-12){instr.i.imm12[11]}}, instr.i.imm12};
            case (instr.i.funct3)
                exu_alu_pkg::f3_add_sub: req_d.op = exu_alu_pkg::alu_add;
                exu_alu_pkg::f3_slt:     req_d.op = exu_alu_pkg::alu_slt;
                exu_alu_pkg::f3_sltu:    req_d.op = exu_alu_pkg::alu_sltu;
                exu_alu_pkg::f3_xor:     req_d.op = exu_alu_pkg::alu_xor;
                exu_alu_pkg::f3_or:      req_d.op = exu_alu_pkg::alu_or;
                exu_alu_pkg::f3_and:     req_d.op = exu_alu_pkg::alu_and;
                // shamt sits in the low bits of op2, upper imm bits are funct7
                exu_alu_pkg::f3_sll:
                    req_d.op = f7_zero ? exu_alu_pkg::alu_sll : exu_alu_pkg::alu_none;
                default:
                    req_d.op = f7_zero ? exu_alu_pkg::alu_srl :
                               f7_alt  ? exu_alu_pkg::alu_sra : exu_alu_pkg::alu_none;
            endcase
        end
        // anything left undecoded is illegal
        req_d.illegal = (req_d.op == exu_alu_pkg::alu_none);
    end

    // stage loads when empty or when its content leaves this cycle
    assign in_ready_o = ~req_valid_o | stage1_ready_i;
    assign load       = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            req_valid_o <= 1'b0;
        end else if (in_ready_o) begin
            req_valid_o <= in_valid_i;
        end
    end

    // payload only
    always_ff @(posedge clk_i) begin
        if (load) begin
            req_o <= req_d;
        end
    end

endmodule

/* logic/exu_alu_shifter.sv */
// exu_alu shift and bitwise block
// one left shifter serves sll, srl and sra; right shifts go through bit reversal
`timescale 1ns/1ps

module exu_alu_shifter (
    input  logic [exu_alu_pkg::xlen-1:0] op1_i,
    input  logic [exu_alu_pkg::xlen-1:0] op2_i,
    input  logic                         op_sll_i,
    input  logic                         op_srl_i,
    input  logic                         op_sra_i,
    input  logic                         op_xor_i,
    input  logic                         op_or_i,
    input  logic                         op_and_i,
    output logic [exu_alu_pkg::xlen-1:0] sll_result_o,
    output logic [exu_alu_pkg::xlen-1:0] srl_result_o,
    output logic [exu_alu_pkg::xlen-1:0] sra_result_o,
    output logic [exu_alu_pkg::xlen-1:0] xor_result_o,
    output logic [exu_alu_pkg::xlen-1:0] or_result_o,
    output logic [exu_alu_pkg::xlen-1:0] and_result_o
);

    localparam int unsigned sh_w = $clog2(exu_alu_pkg::xlen);

    // mirror a word, bit 0 <-> bit xlen-1
    function automatic logic [exu_alu_pkg::xlen-1:0] bit_rev(
        input logic [exu_alu_pkg::xlen-1:0] v
    );
        logic [exu_alu_pkg::xlen-1:0] r;
        for (int k = 0; k < exu_alu_pkg::xlen; k++) begin
            r[k] = v[exu_alu_pkg::xlen-1-k];
        end
        return r;
    endfunction

    logic                         op_shift;
    logic                         op_right;
    logic [exu_alu_pkg::xlen-1:0] shifter_in;
    logic [sh_w-1:0]              shamt;
    logic [exu_alu_pkg::xlen-1:0] shifter_res;
    logic [exu_alu_pkg::xlen-1:0] srl_res;
    logic [exu_alu_pkg::xlen-1:0] sign_mask;

    assign op_shift = op_sll_i | op_srl_i | op_sra_i;
    assign op_right = op_srl_i | op_sra_i;

    // shifter input stays quiet when no shift is requested
    assign shifter_in = {exu_alu_pkg::xlen{op_shift}} & (op_right ? bit_rev(op1_i) : op1_i);
    // only the low 5 bits count, as in RV32I
    assign shamt      = {sh_w{op_shift}} & op2_i[sh_w-1:0];

    assign shifter_res = shifter_in << shamt;

    // right shift = reversed left shift of reversed input
    assign srl_res = bit_rev(shifter_res);

    // upper shamt bits that must take the sign
    assign sign_mask = ~({exu_alu_pkg::xlen{1'b1}} >> shamt);

    assign sll_result_o = shifter_res;
    assign srl_result_o = srl_res;
    assign sra_result_o = srl_res | ({exu_alu_pkg::xlen{op1_i[exu_alu_pkg::xlen-1]}} & sign_mask);

    // bitwise ops, zero unless selected
    assign xor_result_o = {exu_alu_pkg::xlen{op_xor_i}} & (op1_i ^ op2_i);
    assign or_result_o  = {exu_alu_pkg::xlen{op_or_i}}  & (op1_i | op2_i);
    assign and_result_o = {exu_alu_pkg::xlen{op_and_i}} & (op1_i & op2_i);

endmodule

/* logic/exu_alu_adder.sv */
// exu_alu add / subtract block
// a single adder gives add, sub, slt and sltu
`timescale 1ns/1ps

module exu_alu_adder (
    input  logic [exu_alu_pkg::xlen-1:0] op1_i,
    input  logic [exu_alu_pkg::xlen-1:0] op2_i,
    input  logic                         op_sub_i,
    input  logic                         op_slt_i,
    input  logic                         op_sltu_i,
    output logic [exu_alu_pkg::xlen-1:0] sum_o,
    output logic [exu_alu_pkg::xlen-1:0] slt_o,
    output logic [exu_alu_pkg::xlen-1:0] sltu_o
);

    localparam int unsigned msb = exu_alu_pkg::xlen - 1;

    logic                         do_sub;
    logic [exu_alu_pkg::xlen-1:0] op2_adj;
    logic [exu_alu_pkg::xlen:0]   sum_ext;
    logic                         carry;
    logic                         ovf;
    logic                         lt_signed;

    // compares need the difference too
    assign do_sub  = op_sub_i | op_slt_i | op_sltu_i;
    assign op2_adj = op2_i ^ {exu_alu_pkg::xlen{do_sub}};

    // two's complement: invert and add carry-in
    assign sum_ext = {1'b0, op1_i} + {1'b0, op2_adj} + {{exu_alu_pkg::xlen{1'b0}}, do_sub};
    assign carry   = sum_ext[exu_alu_pkg::xlen];

    // signed overflow of op1 - op2
    assign ovf = (op1_i[msb] ^ op2_i[msb]) & (sum_ext[msb] ^ op1_i[msb]);
    assign lt_signed = sum_ext[msb] ^ ovf;

    assign sum_o = sum_ext[msb:0];

    // no carry out of the subtract means op1 < op2 unsigned
    assign slt_o  = {{(exu_alu_pkg::xlen-1){1'b0}}, lt_signed};
    assign sltu_o = {{(exu_alu_pkg::xlen-1){1'b0}}, ~carry};

endmodule

/* logic/exu_alu_result_mux.sv */
// exu_alu output stage
// picks the result for the registered op and holds it under back-pressure
`timescale 1ns/1ps

module exu_alu_result_mux (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         req_valid_i,
    input  exu_alu_pkg::alu_req_t        req_i,
    input  logic [exu_alu_pkg::xlen-1:0] sll_result_i,
    input  logic [exu_alu_pkg::xlen-1:0] srl_result_i,
    input  logic [exu_alu_pkg::xlen-1:0] sra_result_i,
    input  logic [exu_alu_pkg::xlen-1:0] xor_result_i,
    input  logic [exu_alu_pkg::xlen-1:0] or_result_i,
    input  logic [exu_alu_pkg::xlen-1:0] and_result_i,
    input  logic [exu_alu_pkg::xlen-1:0] sum_i,
    input  logic [exu_alu_pkg::xlen-1:0] slt_i,
    input  logic [exu_alu_pkg::xlen-1:0] sltu_i,
    input  logic                         out_ready_i,
    output logic                         stage1_ready_o,
    output logic                         out_valid_o,
    output exu_alu_pkg::alu_rsp_t        out_rsp_o
);

    exu_alu_pkg::alu_rsp_t rsp_d;
    logic                  load;

    always_comb begin
        rsp_d.illegal = req_i.illegal;
        case (req_i.op)
            exu_alu_pkg::alu_add,
            exu_alu_pkg::alu_sub:  rsp_d.result = sum_i;
            exu_alu_pkg::alu_slt:  rsp_d.result = slt_i;
            exu_alu_pkg::alu_sltu: rsp_d.result = sltu_i;
            exu_alu_pkg::alu_sll:  rsp_d.result = sll_result_i;
            exu_alu_pkg::alu_srl:  rsp_d.result = srl_result_i;
            exu_alu_pkg::alu_sra:  rsp_d.result = sra_result_i;
            exu_alu_pkg::alu_xor:  rsp_d.result = xor_result_i;
            exu_alu_pkg::alu_or:   rsp_d.result = or_result_i;
            exu_alu_pkg::alu_and:  rsp_d.result = and_result_i;
            default:               rsp_d.result = '0;
        endcase
        // illegal words always answer zero
        if (req_i.illegal) begin
            rsp_d.result = '0;
        end
    end

    // same load rule as stage 1
    assign stage1_ready_o = ~out_valid_o | out_ready_i;
    assign load           = req_valid_i & stage1_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
        end else if (stage1_ready_o) begin
            out_valid_o <= req_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            out_rsp_o <= rsp_d;
        end
    end

endmodule

/* logic/exu_alu_top.sv */
// exu_alu top level
// decoder -> shifter / adder -> result register, valid/ready on both sides
`timescale 1ns/1ps

module exu_alu_top (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    input  exu_alu_pkg::alu_cmd_t  in_cmd_i,
    output logic                   out_valid_o,
    input  logic                   out_ready_i,
    output exu_alu_pkg::alu_rsp_t  out_rsp_o
);

    logic                         req_valid;
    exu_alu_pkg::alu_req_t        req;
    logic                         stage1_ready;

    // one-hot op strobes
    logic op_sll, op_srl, op_sra, op_xor, op_or, op_and;
    logic op_sub, op_slt, op_sltu;

    logic [exu_alu_pkg::xlen-1:0] sll_res, srl_res, sra_res;
    logic [exu_alu_pkg::xlen-1:0] xor_res, or_res, and_res;
    logic [exu_alu_pkg::xlen-1:0] sum, slt, sltu;

    assign op_sll  = (req.op == exu_alu_pkg::alu_sll);
    assign op_srl  = (req.op == exu_alu_pkg::alu_srl);
    assign op_sra  = (req.op == exu_alu_pkg::alu_sra);
    assign op_xor  = (req.op == exu_alu_pkg::alu_xor);
    assign op_or   = (req.op == exu_alu_pkg::alu_or);
    assign op_and  = (req.op == exu_alu_pkg::alu_and);
    // add leaves all three low, adder then adds
    assign op_sub  = (req.op == exu_alu_pkg::alu_sub);
    assign op_slt  = (req.op == exu_alu_pkg::alu_slt);
    assign op_sltu = (req.op == exu_alu_pkg::alu_sltu);

    exu_alu_decoder i_decoder (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .in_valid_i     (in_valid_i),
        .in_cmd_i       (in_cmd_i),
        .stage1_ready_i (stage1_ready),
        .in_ready_o     (in_ready_o),
        .req_valid_o    (req_valid),
        .req_o          (req)
    );

    exu_alu_shifter i_shifter (
        .op1_i        (req.op1),
        .op2_i        (req.op2),
        .op_sll_i     (op_sll),
        .op_srl_i     (op_srl),
        .op_sra_i     (op_sra),
        .op_xor_i     (op_xor),
        .op_or_i      (op_or),
        .op_and_i     (op_and),
        .sll_result_o (sll_res),
        .srl_result_o (srl_res),
        .sra_result_o (sra_res),
        .xor_result_o (xor_res),
        .or_result_o  (or_res),
        .and_result_o (and_res)
    );

    exu_alu_adder i_adder (
        .op1_i     (req.op1),
        .op2_i     (req.op2),
        .op_sub_i  (op_sub),
        .op_slt_i  (op_slt),
        .op_sltu_i (op_sltu),
        .sum_o     (sum),
        .slt_o     (slt),
        .sltu_o    (sltu)
    );

    exu_alu_result_mux i_result_mux (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .req_valid_i    (req_valid),
        .req_i          (req),
        .sll_result_i   (sll_res),
        .srl_result_i   (srl_res),
        .sra_result_i   (sra_res),
        .xor_result_i   (xor_res),
        .or_result_i    (or_res),
        .and_result_i   (and_res),
        .sum_i          (sum),
        .slt_i          (slt),
        .sltu_i         (sltu),
        .out_ready_i    (out_ready_i),
        .stage1_ready_o (stage1_ready),
        .out_valid_o    (out_valid_o),
        .out_rsp_o      (out_rsp_o)
    );

endmodule

/* testbench/exu_alu_checker.sv */
// exu_alu stream checker
// reset state, output hold under back-pressure and ready while empty
`timescale 1ns/1ps

module exu_alu_checker (
    input logic                  clk_i,
    input logic                  rst_n_i,
    input logic                  in_valid_i,
    input logic                  in_ready_i,
    input logic                  req_valid_i,
    input logic                  out_valid_i,
    input logic                  out_ready_i,
    input exu_alu_pkg::alu_rsp_t out_rsp_i
);

    // items accepted but not yet delivered
    logic [2:0] in_flight;
    logic       take;
    logic       give;

    assign take = in_valid_i & in_ready_i;
    assign give = out_valid_i & out_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            in_flight <= 3'd0;
        end else if (take && !give) begin
            in_flight <= in_flight + 3'd1;
        end else if (give && !take) begin
            in_flight <= in_flight - 3'd1;
        end
    end

    // both stages empty right after a reset cycle
    reset_clears_valid: assert property (@(posedge clk_i)
        !rst_n_i |=> !out_valid_i && !req_valid_i)
        else $error("valid still set in the cycle after reset");

    // stalled response keeps valid and payload
    hold_under_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_rsp_i))
        else $error("output changed while stalled by out_ready_i");

    // nothing in flight means the unit must take a command
    ready_when_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        in_flight == 3'd0 |-> in_ready_i)
        else $error("in_ready_o low although nothing is in flight");

endmodule

bind exu_alu_top exu_alu_checker i_checker (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_i  (in_ready_o),
    .req_valid_i (req_valid),
    .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_rsp_i   (out_rsp_o)
);

/* testbench/exu_alu_tb.sv */
// exu_alu testbench
// file-driven cases with random input gaps and back-pressure and in-order response checks
`timescale 1ns/1ps

module exu_alu_tb;

    localparam int max_cases    = 64;
    localparam int reset_cycles = 16;

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  in_valid_i;
    logic                  in_ready_o;
    exu_alu_pkg::alu_cmd_t in_cmd_i;
    logic                  out_valid_o;
    logic                  out_ready_i;
    exu_alu_pkg::alu_rsp_t out_rsp_o;

    // case table as read from the data file
    string                        case_name [max_cases];
    logic [31:0]                  case_instr [max_cases];
    logic [exu_alu_pkg::xlen-1:0] case_rs1 [max_cases];
    logic [exu_alu_pkg::xlen-1:0] case_rs2 [max_cases];
    logic [exu_alu_pkg::xlen-1:0] case_result [max_cases];
    logic                         case_illegal [max_cases];
    int                           n_cases;

    // indices of accepted cases still waiting for their response
    int          pending [$];
    int          cycle_count = 0;
    int          cycle_limit = 0;
    logic [15:0] lfsr_state;

    exu_alu_top i_dut (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_cmd_i    (in_cmd_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_rsp_o   (out_rsp_o)
    );

    // 4 ns period
    always #2 clk_i = ~clk_i;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped on first error");
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 16'hb400;
        end
        return out;
    endfunction

    // true about once in four draws
    function automatic logic rare_event();
        logic a;
        logic b;
        a = lfsr_bit();
        b = lfsr_bit();
        return a & b;
    endfunction

    task automatic check_result(input string name,
                                input logic [exu_alu_pkg::xlen-1:0] exp,
                                input logic [exu_alu_pkg::xlen-1:0] act);
        if (act !== exp) begin
            stop_run($sformatf("mismatch %s result: expected %08h actual %08h", name, exp, act));
        end
    endtask

    task automatic check_illegal(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("mismatch %s illegal: expected %0b actual %0b", name, exp, act));
        end
    endtask

    task automatic load_cases();
        int          fd;
        int          fields;
        string       line;
        string       name;
        logic [31:0] instr;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] res;
        logic        ill;
        fd = $fopen("testbench/exu_alu_cases.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open the case file testbench/exu_alu_cases.txt");
        end
        n_cases = 0;
        while ($fgets(line, fd) != 0) begin
            // skip blank lines and comments
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%s %h %h %h %h %h", name, instr, rs1, rs2, res, ill);
            if (fields != 6) begin
                stop_run($sformatf("malformed line in case file: %s", line));
            end
            if (n_cases >= max_cases) begin
                stop_run("too many cases in the case file");
            end
            case_name[n_cases]    = name;
            case_instr[n_cases]   = instr;
            case_rs1[n_cases]     = rs1;
            case_rs2[n_cases]     = rs2;
            case_result[n_cases]  = res;
            case_illegal[n_cases] = ill;
            n_cases++;
        end
        $fclose(fd);
        if (n_cases == 0) begin
            stop_run("the case file holds no cases");
        end
    endtask

    // cycle budget counted from time zero
    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            stop_run($sformatf("timeout after %0d cycles, responses still missing", cycle_count));
        end
    end

    initial begin
        int   idx;
        int   k;
        int   answered;
        logic accepted;
        logic extra;
        clk_i       = 1'b0;
        rst_n_i     = 1'b0;
        in_valid_i  = 1'b0;
        in_cmd_i    = '0;
        out_ready_i = 1'b0;
        lfsr_state  = 16'd41;
        idx         = 0;
        answered    = 0;
        accepted    = 1'b0;
        extra       = 1'b0;
        load_cases();
        cycle_limit = 4 * n_cases + reset_cycles + 100;
        repeat (reset_cycles) @(posedge clk_i);
        #0.5;
        rst_n_i = 1'b1;
        // idle state before the first command
        @(negedge clk_i);
        if (out_valid_o !== 1'b0) begin
            stop_run("out_valid_o is not low after reset");
        end
        if (in_ready_o !== 1'b1) begin
            stop_run("in_ready_o is not high after reset");
        end
        while (answered < n_cases) begin
            @(posedge clk_i);
            #0.5;
            // a held command stays until it is taken
            if (!in_valid_i || accepted) begin
                if (idx < n_cases && !rare_event()) begin
                    in_valid_i = 1'b1;
                    in_cmd_i   = {case_instr[idx], case_rs1[idx], case_rs2[idx]};
                end else begin
                    in_valid_i = 1'b0;
                end
            end
            out_ready_i = !rare_event();
            // sample the transfers of the coming edge at the falling edge
            @(negedge clk_i);
            accepted = in_valid_i && in_ready_o;
            if (out_valid_o && out_ready_i) begin
                if (pending.size() == 0) begin
                    stop_run("response seen with no command pending");
                end
                k = pending.pop_front();
                check_result(case_name[k], case_result[k], out_rsp_o.result);
                check_illegal(case_name[k], case_illegal[k], out_rsp_o.illegal);
                answered++;
            end
            if (accepted) begin
                pending.push_back(idx);
                idx++;
            end
        end
        // no stray response after the last one
        repeat (3) begin
            @(posedge clk_i);
            #0.5;
            in_valid_i  = 1'b0;
            out_ready_i = 1'b1;
            @(negedge clk_i);
            if (out_valid_o) begin
                extra = 1'b1;
            end
        end
        if (!extra && pending.size() == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            stop_run("extra response after all cases were answered");
        end
    end

endmodule

/* testbench/exu_alu_cases.txt */
# name instr rs1 rs2 expected_result expected_illegal, all values hex
# rd x5, rs1 x6, rs2 x7; rs2 is ignored by OP-IMM words
sll_0 007312b3 80000001 00000000 80000001 0
sll_1 007312b3 80000001 00000001 00000002 0
sll_31 007312b3 00000003 0000001f 80000000 0
sll_rs2_hi 007312b3 00000001 ffffffe4 00000010 0
srl_1_neg 007352b3 80000000 00000001 40000000 0
srl_31_neg 007352b3 f0000000 0000001f 00000001 0
srl_rs2_hi 007352b3 12345678 00000124 01234567 0
sra_0_neg 407352b3 80000000 00000000 80000000 0
sra_1_neg 407352b3 80000000 00000001 c0000000 0
sra_31_neg 407352b3 80000000 0000001f ffffffff 0
sra_31_pos 407352b3 7fffffff 0000001f 00000000 0
slli_1 00131293 40000001 deadbeef 80000002 0
slli_31 01f31293 00000001 deadbeef 80000000 0
srli_0 00035293 80000000 deadbeef 80000000 0
srli_31 01f35293 ffffffff deadbeef 00000001 0
srai_1 40135293 80000010 deadbeef c0000008 0
srai_31_neg 41f35293 80000000 deadbeef ffffffff 0
srai_31_pos 41f35293 7fffffff deadbeef 00000000 0
xor 007342b3 ff00ff00 0ff00ff0 f0f0f0f0 0
or 007362b3 12340000 00005678 12345678 0
and 007372b3 f0f0f0f0 ff00ff00 f000f000 0
xori_m1 fff34293 0f0f0f0f deadbeef f0f0f0f0 0
ori_m2048 80036293 00000123 deadbeef fffff923 0
andi_m16 ff037293 1234567f deadbeef 12345670 0
add_ovf 007302b3 7fffffff 00000001 80000000 0
add_wrap 007302b3 ffffffff 00000001 00000000 0
sub_ovf 407302b3 80000000 00000001 7fffffff 0
sub_zero 407302b3 00000000 00000001 ffffffff 0
addi_m1 fff30293 00000000 deadbeef ffffffff 0
addi_max 7ff30293 7fffffff deadbeef 800007fe 0
slt_min_max 007322b3 80000000 7fffffff 00000001 0
slt_max_min 007322b3 7fffffff 80000000 00000000 0
slt_m1_0 007322b3 ffffffff 00000000 00000001 0
sltu_0_ones 007332b3 00000000 ffffffff 00000001 0
sltu_ones_0 007332b3 ffffffff 00000000 00000000 0
sltu_min_max 007332b3 80000000 7fffffff 00000000 0
slti_m1 fff32293 80000000 deadbeef 00000001 0
sltiu_m1 fff33293 7fffffff deadbeef 00000001 0
bad_opcode 123452b7 ffffffff ffffffff 00000000 1
bad_funct7_op 027302b3 00000005 00000003 00000000 1
bad_funct7_srai 60135293 80000000 deadbeef 00000000 1

/* exu_alu.f */
logic/exu_alu_pkg.sv
logic/exu_alu_decoder.sv
logic/exu_alu_shifter.sv
logic/exu_alu_adder.sv
logic/exu_alu_result_mux.sv
logic/exu_alu_top.sv
testbench/exu_alu_checker.sv
testbench/exu_alu_tb.sv

/* Makefile */
# Verilator build and run of the exu_alu testbench

VERILATOR ?= verilator
TOP       ?= exu_alu_tb
FILELIST  ?= exu_alu.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "STATUS: FAIL" $(LOG) || \
		! grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
